//--- files.f
+incdir+source
+incdir+verification
source/procPkg.sv
source/registerBank.sv
source/accumulatorAlu.sv
source/controlUnit.sv
source/procTop.sv
verification/procTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module procTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VprocTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

//--- verification/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Instruction level model of the processor
// Runs instrRom on modelRam and queues every store in program order
task automatic executeProgram();
  logic [7:0] regs [0:`RO_IR];
  logic [7:0] pcModel;
  logic [7:0] instr;
  logic [7:0] operand;
  logic [3:0] r;
  logic       valid;
  logic       taken;
  logic       done;
  int         steps;

  for (int i = 0; i <= `RO_IR; i++) begin
    regs[i] = 8'h00;
  end
  pcModel = `PC_RESET;
  done    = 1'b0;
  steps   = 0;
  expAddr.delete();
  expData.delete();
  while (!done && steps < 256) begin
    instr   = instrRom[pcModel];
    pcModel = pcModel + 8'd1;
    r       = instr[3:0];
    valid   = (r <= 4'(`RO_IR));
    // IR reads back as the instruction being executed
    regs[`RO_IR] = instr;
    operand = valid ? regs[r] : 8'h00;
    case (opcode_t'(instr[7:4]))
      OP_LD:   if (valid) regs[r] = modelRam[regs[`RO_RP]];
      OP_ST: begin
        if (valid) begin
          expAddr.push_back(regs[`RO_CP]);
          expData.push_back(operand);
          modelRam[regs[`RO_CP]] = operand;
        end
      end
      OP_ADD:  if (valid) regs[`RO_AC] = regs[`RO_AC] + operand;
      OP_SUB:  if (valid) regs[`RO_AC] = regs[`RO_AC] - operand;
      OP_AND:  if (valid) regs[`RO_AC] = regs[`RO_AC] & operand;
      OP_XOR:  if (valid) regs[`RO_AC] = regs[`RO_AC] ^ operand;
      OP_LDA:  if (valid) regs[`RO_AC] = operand;
      OP_MOVA: if (valid) regs[r] = regs[`RO_AC];
      OP_INC:  if (valid) regs[r] = regs[r] + 8'd1;
      OP_CLR:  if (valid) regs[r] = 8'h00;
      OP_SHL:  regs[`RO_AC] = {regs[`RO_AC][6:0], 1'b0};
      OP_JMP, OP_JEQC, OP_JNEM: begin
        taken = (instr[7:4] == OP_JMP)
             || (instr[7:4] == OP_JEQC && regs[`RO_CID] == regs[`RO_EOPC])
             || (instr[7:4] == OP_JNEM && regs[`RO_MC] != regs[`RO_MV]);
        // Target byte is used up whether or not the jump is taken
        pcModel = taken ? instrRom[pcModel] : pcModel + 8'd1;
      end
      OP_HALT: done = 1'b1;
      default: ;
    endcase
    steps++;
  end
  if (!done) begin
    errors++;
    $display("Model ran %0d steps without reaching HALT", steps);
  end
  // PC has already stepped past the HALT byte
  expHaltPc = pcModel;
endtask

`endif

//--- verification/procTb.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module procTb import procPkg::*; ();

  localparam int NUM_PROGS = 20;
  localparam int MAX_RAND  = 40;
  localparam int RESET_LEN = 4;
  localparam int HOLD_LEN  = 10;
  // 60 instructions of 4 cycles plus 20 cycles of reset and hold, per program
  localparam int CYCLE_LIMIT = NUM_PROGS * (4 * 60 + 20);

  logic               CLK;
  logic               arstN;
  logic [`DATA_W-1:0] iAddress;
  logic [`DATA_W-1:0] iDin;
  logic [`DATA_W-1:0] dAddress;
  logic [`DATA_W-1:0] dDin;
  logic [`DATA_W-1:0] dDout;
  logic               memCtrl;
  logic               halted;

  logic [7:0] instrRom [0:255];
  logic [7:0] dataRam  [0:255];
  logic [7:0] modelRam [0:255];
  logic [7:0] expAddr  [$];
  logic [7:0] expData  [$];
  logic [7:0] gotAddr  [$];
  logic [7:0] gotData  [$];
  logic [7:0] expHaltPc;
  integer     seed;
  int         errors;
  int         storeCount;
  int         cycleCount;

  // Both memories answer in the same cycle
  assign iDin = instrRom[iAddress];
  assign dDin = dataRam[dAddress];

  procTop DUT (
    .CLK      (CLK),
    .arstN    (arstN),
    .iAddress (iAddress),
    .iDin     (iDin),
    .dAddress (dAddress),
    .dDin     (dDin),
    .dDout    (dDout),
    .memCtrl  (memCtrl),
    .halted   (halted)
  );

  always #5 CLK = ~CLK;

  always @(negedge CLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  `include "isaModel.svh"

  task automatic reportValue(string name, int expected, int actual);
    errors++;
    $display("FAILED %s expected 0x%02h actual 0x%02h", name, expected, actual);
  endtask

  // Stores are taken at the falling edge of the EXEC cycle
  task automatic stepCycle();
    @(negedge CLK);
    if (memCtrl === 1'b1) begin
      gotAddr.push_back(dAddress);
      gotData.push_back(dDout);
      dataRam[dAddress] = dDout;
    end
  endtask

  task automatic checkResetState(int p);
    if (iAddress !== `PC_RESET) begin
      reportValue($sformatf("prog %0d reset iAddress", p), `PC_RESET, iAddress);
    end
    if (memCtrl !== 1'b0) begin
      reportValue($sformatf("prog %0d reset memCtrl", p), 0, memCtrl);
    end
    if (halted !== 1'b0) begin
      reportValue($sformatf("prog %0d reset halted", p), 0, halted);
    end
  endtask

  // Saves AC, builds 0xF0 in AC for CP, then stores every register code
  task automatic appendEpilogue(int addr);
    logic [7:0] code [$];
    code.push_back({OP_ST, 4'(`RO_AC)});
    code.push_back({OP_CLR, 4'(`RO_AC)});
    code.push_back({OP_INC, 4'(`RO_AC)});
    for (int k = 0; k < 3; k++) begin
      code.push_back({OP_SHL, 4'h0});
      code.push_back({OP_INC, 4'(`RO_AC)});
    end
    for (int k = 0; k < 4; k++) begin
      code.push_back({OP_SHL, 4'h0});
    end
    code.push_back({OP_MOVA, 4'(`RO_CP)});
    for (int r = 0; r <= `RO_IR; r++) begin
      code.push_back({OP_ST, 4'(r)});
      if (r < `RO_IR) begin
        code.push_back({OP_INC, 4'(`RO_CP)});
      end
    end
    code.push_back({OP_HALT, 4'h0});
    foreach (code[k]) begin
      instrRom[addr + k] = code[k];
    end
  endtask

  task automatic buildProgram();
    logic [7:0] body  [0:MAX_RAND-1];
    int         start [0:MAX_RAND];
    logic [3:0] opPick;
    logic [3:0] regPick;
    int         count;
    int         addr;
    int         pick;
    for (int a = 0; a < 256; a++) begin
      // Unused bytes decode as HALT
      instrRom[a] = {4'hF, a[7:4] ^ a[3:0]};
      dataRam[a]  = 8'($random(seed));
      modelRam[a] = dataRam[a];
    end
    count = 1 + ($unsigned($random(seed)) % MAX_RAND);
    addr  = 0;
    for (int i = 0; i < count; i++) begin
      // HALT stays out of the random part
      opPick   = 4'($unsigned($random(seed)) % 15);
      regPick  = 4'($random(seed));
      body[i]  = {opPick, regPick};
      start[i] = addr;
      addr     = addr + ((opPick >= OP_JMP) ? 2 : 1);
    end
    start[count] = addr;
    for (int i = 0; i < count; i++) begin
      instrRom[start[i]] = body[i];
      if (body[i][7:4] >= OP_JMP) begin
        // Forward only, at most to the epilogue
        pick = i + 1 + ($unsigned($random(seed)) % (count - i));
        instrRom[start[i] + 1] = 8'(start[pick]);
      end
    end
    appendEpilogue(addr);
  endtask

  task automatic compareStores(int p);
    if (gotAddr.size() != expAddr.size()) begin
      reportValue($sformatf("prog %0d store count", p), expAddr.size(), gotAddr.size());
    end
    for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
      storeCount++;
      if (gotAddr[i] !== expAddr[i]) begin
        reportValue($sformatf("prog %0d store %0d address", p, i), expAddr[i], gotAddr[i]);
      end
      if (gotData[i] !== expData[i]) begin
        reportValue($sformatf("prog %0d store %0d data", p, i), expData[i], gotData[i]);
      end
    end
  endtask

  task automatic runProgram(int p);
    int storesAtHalt;
    arstN = 1'b0;
    buildProgram();
    executeProgram();
    gotAddr.delete();
    gotData.delete();
    for (int c = 0; c < RESET_LEN; c++) begin
      stepCycle();
      checkResetState(p);
    end
    arstN = 1'b1;
    stepCycle();
    checkResetState(p);
    while (halted !== 1'b1) begin
      stepCycle();
    end
    if (iAddress !== expHaltPc) begin
      reportValue($sformatf("prog %0d halt iAddress", p), expHaltPc, iAddress);
    end
    storesAtHalt = gotAddr.size();
    for (int c = 0; c < HOLD_LEN; c++) begin
      stepCycle();
      if (halted !== 1'b1) begin
        errors++;
        $display("Program %0d left the halted state without a reset", p);
      end
      if (iAddress !== expHaltPc) begin
        reportValue($sformatf("prog %0d halted iAddress", p), expHaltPc, iAddress);
      end
    end
    if (gotAddr.size() != storesAtHalt) begin
      errors++;
      $display("Program %0d wrote data memory after HALT", p);
    end
    compareStores(p);
  endtask

  initial begin
    CLK        = 1'b0;
    arstN      = 1'b0;
    seed       = 32'h275a_ffe1;
    errors     = 0;
    storeCount = 0;
    cycleCount = 0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      runProgram(p);
    end
    $display("Programs: %0d  stores compared: %0d  errors: %0d", NUM_PROGS, storeCount, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- source/procTop.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module procTop import procPkg::*; (
  input  logic               CLK,
  input  logic               arstN,
  output logic [`DATA_W-1:0] iAddress,
  input  logic [`DATA_W-1:0] iDin,
  output logic [`DATA_W-1:0] dAddress,
  input  logic [`DATA_W-1:0] dDin,
  output logic [`DATA_W-1:0] dDout,
  output logic               memCtrl,
  output logic               halted
);

  logic [`REG_COUNT-1:0] wrEn;
  logic [`REG_COUNT-1:0] clrEn;
  logic [`REG_COUNT-1:0] incEn;
  logic                  irLoad;
  logic                  busFromData;
  regCode_t              busSel;
  ptrSel_t               ptrSel;
  aluOp_t                aluOp;
  logic [`DATA_W-1:0]    bus;
  logic [`DATA_W-1:0]    ir;
  logic [`DATA_W-1:0]    acValue;
  logic                  z1;
  logic                  z2;

  // Store data is whatever the bus carries
  assign dDout = bus;

  registerBank regBank (
    .CLK         (CLK),
    .arstN       (arstN),
    .wrEn        (wrEn),
    .clrEn       (clrEn),
    .incEn       (incEn),
    .irLoad      (irLoad),
    .busSel      (busSel),
    .busFromData (busFromData),
    .ptrSel      (ptrSel),
    .iDin        (iDin),
    .dDin        (dDin),
    .acValue     (acValue),
    .bus         (bus),
    .ir          (ir),
    .pc          (iAddress),
    .dAddress    (dAddress),
    .z1          (z1),
    .z2          (z2)
  );

  accumulatorAlu acAlu (
    .CLK     (CLK),
    .arstN   (arstN),
    .wrEn    (wrEn[`RO_AC]),
    .clrEn   (clrEn[`RO_AC]),
    .incEn   (incEn[`RO_AC]),
    .aluOp   (aluOp),
    .bus     (bus),
    .acValue (acValue)
  );

  controlUnit ctrl (
    .CLK         (CLK),
    .arstN       (arstN),
    .ir          (ir),
    .z1          (z1),
    .z2          (z2),
    .wrEn        (wrEn),
    .clrEn       (clrEn),
    .incEn       (incEn),
    .irLoad      (irLoad),
    .busSel      (busSel),
    .busFromData (busFromData),
    .ptrSel      (ptrSel),
    .aluOp       (aluOp),
    .memCtrl     (memCtrl),
    .halted      (halted)
  );

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module controlUnit import procPkg::*; (
  input  logic                  CLK,
  input  logic                  arstN,
  input  logic [`DATA_W-1:0]    ir,
  input  logic                  z1,
  input  logic                  z2,
  output logic [`REG_COUNT-1:0] wrEn,
  output logic [`REG_COUNT-1:0] clrEn,
  output logic [`REG_COUNT-1:0] incEn,
  output logic                  irLoad,
  output regCode_t              busSel,
  output logic                  busFromData,
  output ptrSel_t               ptrSel,
  output aluOp_t                aluOp,
  output logic                  memCtrl,
  output logic                  halted
);

  ctrlState_t state;
  ctrlState_t nextState;
  opcode_t    opcode;
  regCode_t   regCode;
  logic       regValid;
  logic       jumpCond;
  logic       takeJump;

  assign opcode   = opcode_t'(ir[7:4]);
  assign regCode  = regCode_t'(ir[3:0]);
  assign regValid = (ir[3:0] <= 4'(`RO_IR));
  assign halted   = (state == ST_HALTED);

  // Flags are stable from EXEC on, so decide the jump there
  always_comb begin
    case (opcode)
      OP_JMP:  jumpCond = 1'b1;
      OP_JEQC: jumpCond = z1;
      OP_JNEM: jumpCond = !z2;
      default: jumpCond = 1'b0;
    endcase
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state    <= ST_RESET;
      takeJump <= 1'b0;
    end else begin
      state <= nextState;
      if (state == ST_EXEC) begin
        takeJump <= jumpCond;
      end
    end
  end

  always_comb begin
    nextState   = state;
    wrEn        = '0;
    clrEn       = '0;
    incEn       = '0;
    irLoad      = 1'b0;
    busSel      = regCode;
    busFromData = 1'b0;
    ptrSel      = PTR_GSP;
    aluOp       = ALU_PASS;
    memCtrl     = 1'b0;

    case (state)
      ST_RESET: nextState = ST_FETCH;
      ST_FETCH: begin
        irLoad             = 1'b1;
        incEn[`RO_PC]      = 1'b1;
        nextState          = ST_EXEC;
      end
      ST_EXEC: begin
        nextState = ST_FETCH;
        case (opcode)
          OP_LD: begin
            busFromData = 1'b1;
            ptrSel      = PTR_RP;
            if (regValid) begin
              wrEn[regCode] = 1'b1;
            end
          end
          OP_ST: begin
            ptrSel  = PTR_CP;
            memCtrl = regValid;
          end
          OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LDA: begin
            case (opcode)
              OP_ADD:  aluOp = ALU_ADD;
              OP_SUB:  aluOp = ALU_SUB;
              OP_AND:  aluOp = ALU_AND;
              OP_XOR:  aluOp = ALU_XOR;
              default: aluOp = ALU_PASS;
            endcase
            wrEn[`RO_AC] = regValid;
          end
          OP_MOVA: begin
            busSel = REG_AC;
            if (regValid) begin
              wrEn[regCode] = 1'b1;
            end
          end
          OP_INC: begin
            if (regValid) begin
              incEn[regCode] = 1'b1;
            end
          end
          OP_CLR: begin
            if (regValid) begin
              clrEn[regCode] = 1'b1;
            end
          end
          OP_SHL: begin
            aluOp        = ALU_SHL;
            wrEn[`RO_AC] = 1'b1;
          end
          OP_JMP, OP_JEQC, OP_JNEM: nextState = ST_JTARGET;
          OP_HALT: nextState = ST_HALTED;
          default: ;
        endcase
      end
      ST_JTARGET: begin
        // Target byte goes into IR, PC steps past it either way
        irLoad        = 1'b1;
        incEn[`RO_PC] = 1'b1;
        nextState     = ST_JLOAD;
      end
      ST_JLOAD: begin
        wrEn[`RO_PC] = takeJump;
        nextState    = ST_FETCH;
      end
      default: nextState = ST_HALTED;
    endcase
  end

  memOnlyInExec: assert property (
    @(posedge CLK) disable iff (!arstN)
    memCtrl |-> (state == ST_EXEC)
  ) else $error("memory write outside EXEC");

  quietWhenHalted: assert property (
    @(posedge CLK) disable iff (!arstN)
    halted |-> (wrEn == '0 && clrEn == '0 && incEn == '0 && !irLoad && !memCtrl)
  ) else $error("strobe active after HALT");

endmodule

//--- source/accumulatorAlu.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module accumulatorAlu import procPkg::*; (
  input  logic               CLK,
  input  logic               arstN,
  input  logic               wrEn,
  input  logic               clrEn,
  input  logic               incEn,
  input  aluOp_t             aluOp,
  input  logic [`DATA_W-1:0] bus,
  output logic [`DATA_W-1:0] acValue
);

  logic [`DATA_W-1:0] aluResult;

  // All results wrap modulo 256
  always_comb begin
    case (aluOp)
      ALU_PASS: aluResult = bus;
      ALU_ADD:  aluResult = acValue + bus;
      ALU_SUB:  aluResult = acValue - bus;
      ALU_AND:  aluResult = acValue & bus;
      ALU_XOR:  aluResult = acValue ^ bus;
      ALU_SHL:  aluResult = {acValue[`DATA_W-2:0], 1'b0};
      default:  aluResult = bus;
    endcase
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      acValue <= '0;
    end else if (clrEn) begin
      acValue <= '0;
    end else if (wrEn) begin
      acValue <= aluResult;
    end else if (incEn) begin
      acValue <= acValue + 1'b1;
    end
  end

  // Control unit only issues the six defined operations
  aluOpDefined: assert property (
    @(posedge CLK) disable iff (!arstN)
    wrEn |-> (aluOp inside {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_SHL})
  ) else $error("undefined ALU operation on accumulator write");

endmodule

//--- source/registerBank.sv
`timescale 1ns/1ps
`include "proc_defines.svh"

module registerBank import procPkg::*; (
  input  logic                  CLK,
  input  logic                  arstN,
  input  logic [`REG_COUNT-1:0] wrEn,
  input  logic [`REG_COUNT-1:0] clrEn,
  input  logic [`REG_COUNT-1:0] incEn,
  input  logic                  irLoad,
  input  regCode_t              busSel,
  input  logic                  busFromData,
  input  ptrSel_t               ptrSel,
  input  logic [`DATA_W-1:0]    iDin,
  input  logic [`DATA_W-1:0]    dDin,
  input  logic [`DATA_W-1:0]    acValue,
  output logic [`DATA_W-1:0]    bus,
  output logic [`DATA_W-1:0]    ir,
  output logic [`DATA_W-1:0]    pc,
  output logic [`DATA_W-1:0]    dAddress,
  output logic                  z1,
  output logic                  z2
);

  // GSP through ADDR; AC lives in the ALU
  logic [`DATA_W-1:0] regFile [0:`RO_ADDR];

  // Clear wins over write, write over increment
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i <= `RO_ADDR; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      for (int i = 0; i <= `RO_ADDR; i++) begin
        if (clrEn[i]) begin
          regFile[i] <= '0;
        end else if (wrEn[i]) begin
          regFile[i] <= bus;
        end else if (incEn[i]) begin
          regFile[i] <= regFile[i] + 1'b1;
        end
      end
    end
  end

  // Strobes on IR only matter until the next fetch overwrites it
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ir <= '0;
    end else if (irLoad) begin
      ir <= iDin;
    end else if (clrEn[`RO_IR]) begin
      ir <= '0;
    end else if (wrEn[`RO_IR]) begin
      ir <= bus;
    end else if (incEn[`RO_IR]) begin
      ir <= ir + 1'b1;
    end
  end

  // Jump target comes from IR, not from the bus
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      pc <= `PC_RESET;
    end else if (clrEn[`RO_PC]) begin
      pc <= `PC_RESET;
    end else if (wrEn[`RO_PC]) begin
      pc <= ir;
    end else if (incEn[`RO_PC]) begin
      pc <= pc + 1'b1;
    end
  end

  always_comb begin
    bus = '0;
    if (busFromData) begin
      bus = dDin;
    end else begin
      case (busSel)
        REG_AC: bus = acValue;
        REG_IR: bus = ir;
        default: begin
          // Codes past ADDR read as zero
          if (4'(busSel) <= 4'(`RO_ADDR)) begin
            bus = regFile[busSel];
          end
        end
      endcase
    end
  end

  always_comb begin
    case (ptrSel)
      PTR_GSP: dAddress = regFile[`RO_GSP];
      PTR_RP:  dAddress = regFile[`RO_RP];
      PTR_CP:  dAddress = regFile[`RO_CP];
      default: dAddress = regFile[`RO_STP];
    endcase
  end

  assign z1 = (regFile[`RO_CID] == regFile[`RO_EOPC]);
  assign z2 = (regFile[`RO_MC] == regFile[`RO_MV]);

  // Decoder must never ask one register for a load and a count together
  wrIncExclusive: assert property (
    @(posedge CLK) disable iff (!arstN)
    (wrEn & incEn) == '0
  ) else $error("write and increment on the same register");

endmodule

//--- source/procPkg.sv
`include "proc_defines.svh"

package procPkg;

  // Top nibble of the instruction byte
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LD   = 4'h1,
    OP_ST   = 4'h2,
    OP_ADD  = 4'h3,
    OP_SUB  = 4'h4,
    OP_AND  = 4'h5,
    OP_XOR  = 4'h6,
    OP_LDA  = 4'h7,
    OP_MOVA = 4'h8,
    OP_INC  = 4'h9,
    OP_CLR  = 4'hA,
    OP_SHL  = 4'hB,
    OP_JMP  = 4'hC,
    OP_JEQC = 4'hD,
    OP_JNEM = 4'hE,
    OP_HALT = 4'hF
  } opcode_t;

  // Bottom nibble, same order as the strobe bits; 13 to 15 are invalid
  typedef enum logic [3:0] {
    REG_GSP  = 4'(`RO_GSP),
    REG_RP   = 4'(`RO_RP),
    REG_CP   = 4'(`RO_CP),
    REG_STP  = 4'(`RO_STP),
    REG_CID  = 4'(`RO_CID),
    REG_EOPC = 4'(`RO_EOPC),
    REG_MC   = 4'(`RO_MC),
    REG_MV   = 4'(`RO_MV),
    REG_WV   = 4'(`RO_WV),
    REG_MULR = 4'(`RO_MULR),
    REG_ADDR = 4'(`RO_ADDR),
    REG_AC   = 4'(`RO_AC),
    REG_IR   = 4'(`RO_IR)
  } regCode_t;

  typedef enum logic [2:0] {
    ALU_PASS = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SHL  = 3'd5
  } aluOp_t;

  // Source of the data memory address
  typedef enum logic [1:0] {
    PTR_GSP = 2'd0,
    PTR_RP  = 2'd1,
    PTR_CP  = 2'd2,
    PTR_STP = 2'd3
  } ptrSel_t;

  typedef enum logic [2:0] {
    ST_RESET   = 3'd0,
    ST_FETCH   = 3'd1,
    ST_EXEC    = 3'd2,
    ST_JTARGET = 3'd3,
    ST_JLOAD   = 3'd4,
    ST_HALTED  = 3'd5
  } ctrlState_t;

endpackage

//--- source/proc_defines.svh
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// Datapath and address width
`define DATA_W 8

// Strobe vector covers the bus registers plus the PC
`define REG_COUNT 14

// Strobe bit of each register, also its bus code
`define RO_GSP  0
`define RO_RP   1
`define RO_CP   2
`define RO_STP  3
`define RO_CID  4
`define RO_EOPC 5
`define RO_MC   6
`define RO_MV   7
`define RO_WV   8
`define RO_MULR 9
`define RO_ADDR 10
`define RO_AC   11
`define RO_IR   12
`define RO_PC   13

// Fetch starts here
`define PC_RESET 8'h00

`endif
